// ==== hdl/null_src_sink_pkg.sv ====
`default_nettype none

package null_src_sink_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int TDATA_W    = 64;
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int CNT_W      = 32;
  localparam int FIELD_W    = 16;
  localparam int RB_DATA_W  = 64;

  // Block identifier returned on readback address 0
  localparam logic [RB_DATA_W-1:0] NOC_ID = 64'hDEAD_BEEF_0123_4567;

  //////////////////////////////
  // Settings register map
  //////////////////////////////
  localparam logic [SET_ADDR_W-1:0] SR_BASE   = 8'd8;
  localparam logic [SET_ADDR_W-1:0] SR_LINES  = SR_BASE + 8'd0;
  localparam logic [SET_ADDR_W-1:0] SR_RATE   = SR_BASE + 8'd1;
  localparam logic [SET_ADDR_W-1:0] SR_ENABLE = SR_BASE + 8'd2;
  localparam logic [SET_ADDR_W-1:0] SR_CLEAR  = SR_BASE + 8'd3;

  // Payload lines per packet out of reset
  localparam logic [FIELD_W-1:0] RESET_LINES = 16'd1;

  //////////////////////////////
  // Bus and stream types
  //////////////////////////////
  // Settings write qualified by a separate strobe
  typedef struct packed {
    logic [SET_ADDR_W-1:0] addr;
    logic [SET_DATA_W-1:0] data;
  } set_bus_t;

  // One stream line
  typedef struct packed {
    logic [TDATA_W-1:0] tdata;
    logic               tlast;
  } axis_beat_t;

  // Any other readback address reads as zero
  typedef enum logic [SET_ADDR_W-1:0] {
    RB_NOC_ID     = 8'd0,
    RB_SINK_PKTS  = 8'd1,
    RB_SINK_LINES = 8'd2,
    RB_SRC_PKTS   = 8'd3,
    RB_SETTINGS   = 8'd4
  } rb_sel_t;

  // Source FSM states
  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_HEADER,
    SRC_PAYLOAD,
    SRC_GAP
  } src_state_t;

endpackage

`default_nettype wire

// ==== hdl/null_source.sv ====
`timescale 1ns/1ns
`default_nettype none

module null_source (
  input  wire                                        i_ce_clk,
  input  wire                                        i_arst_n,
  input  wire                                        i_set_stb,
  input  wire null_src_sink_pkg::set_bus_t           i_set,
  output null_src_sink_pkg::axis_beat_t              o_src_beat,
  output logic                                       o_src_tvalid,
  input  wire                                        i_src_tready,
  output logic [null_src_sink_pkg::CNT_W-1:0]        o_pkts_sent,
  output logic [null_src_sink_pkg::CNT_W-1:0]        o_settings
);

  null_src_sink_pkg::src_state_t            state_q;
  null_src_sink_pkg::src_state_t            state_d;
  logic [null_src_sink_pkg::FIELD_W-1:0]    lines_q;
  logic [null_src_sink_pkg::FIELD_W-1:0]    rate_q;
  logic                                     enable_q;
  logic [null_src_sink_pkg::FIELD_W-1:0]    lines_eff;
  logic [null_src_sink_pkg::FIELD_W-1:0]    pkt_lines_q;
  logic [null_src_sink_pkg::FIELD_W-1:0]    line_cnt_q;
  logic [null_src_sink_pkg::FIELD_W-1:0]    gap_cnt_q;
  logic [null_src_sink_pkg::CNT_W-1:0]      seq_q;
  logic                                     done_q;
  logic                                     xfer;
  logic                                     pkt_end;
  logic                                     enter_header;

  //////////////////////////////
  // Settings registers
  //////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lines_q  <= null_src_sink_pkg::RESET_LINES;
      rate_q   <= '0;
      enable_q <= 1'b0;
    end else if (i_set_stb) begin
      case (i_set.addr)
        null_src_sink_pkg::SR_LINES:  lines_q  <= i_set.data[null_src_sink_pkg::FIELD_W-1:0];
        null_src_sink_pkg::SR_RATE:   rate_q   <= i_set.data[null_src_sink_pkg::FIELD_W-1:0];
        null_src_sink_pkg::SR_ENABLE: enable_q <= i_set.data[0];
        default: ;
      endcase
    end
  end

  // Zero lines behaves as one
  assign lines_eff  = (lines_q == '0) ? 16'd1 : lines_q;
  assign o_settings = {rate_q, lines_q};

  //////////////////////////////
  // Packet FSM
  //////////////////////////////
  assign xfer    = o_src_tvalid && i_src_tready;
  assign pkt_end = (state_q == null_src_sink_pkg::SRC_PAYLOAD) &&
                   (line_cnt_q == pkt_lines_q - 16'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      null_src_sink_pkg::SRC_IDLE: begin
        if (enable_q) begin
          state_d = null_src_sink_pkg::SRC_HEADER;
        end
      end
      null_src_sink_pkg::SRC_HEADER, null_src_sink_pkg::SRC_PAYLOAD: begin
        if (xfer) begin
          if (rate_q != '0) begin
            state_d = null_src_sink_pkg::SRC_GAP;
          end else if (!pkt_end) begin
            state_d = null_src_sink_pkg::SRC_PAYLOAD;
          end else if (enable_q) begin
            state_d = null_src_sink_pkg::SRC_HEADER;
          end else begin
            state_d = null_src_sink_pkg::SRC_IDLE;
          end
        end
      end
      null_src_sink_pkg::SRC_GAP: begin
        // Resume mid-packet, or start over once the last line has gone
        if (gap_cnt_q == '0) begin
          if (!done_q) begin
            state_d = null_src_sink_pkg::SRC_PAYLOAD;
          end else if (enable_q) begin
            state_d = null_src_sink_pkg::SRC_HEADER;
          end else begin
            state_d = null_src_sink_pkg::SRC_IDLE;
          end
        end
      end
      default: state_d = null_src_sink_pkg::SRC_IDLE;
    endcase
  end

  assign enter_header = (state_d == null_src_sink_pkg::SRC_HEADER) &&
                        (state_q != null_src_sink_pkg::SRC_HEADER);

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q     <= null_src_sink_pkg::SRC_IDLE;
      pkt_lines_q <= null_src_sink_pkg::RESET_LINES;
      line_cnt_q  <= '0;
      gap_cnt_q   <= '0;
      seq_q       <= '0;
      done_q      <= 1'b0;
      o_pkts_sent <= '0;
    end else begin
      state_q <= state_d;
      // Length is frozen for the whole packet
      if (enter_header) begin
        pkt_lines_q <= lines_eff;
        line_cnt_q  <= '0;
      end else if (xfer && (state_q == null_src_sink_pkg::SRC_PAYLOAD)) begin
        line_cnt_q <= line_cnt_q + 16'd1;
      end
      if (xfer) begin
        gap_cnt_q <= rate_q - 16'd1;
        done_q    <= pkt_end;
      end else if (state_q == null_src_sink_pkg::SRC_GAP && gap_cnt_q != '0) begin
        gap_cnt_q <= gap_cnt_q - 16'd1;
      end
      if (xfer && pkt_end) begin
        seq_q       <= seq_q + 32'd1;
        o_pkts_sent <= o_pkts_sent + 32'd1;
      end
    end
  end

  //////////////////////////////
  // Output line
  //////////////////////////////
  assign o_src_tvalid = (state_q == null_src_sink_pkg::SRC_HEADER) ||
                        (state_q == null_src_sink_pkg::SRC_PAYLOAD);

  always_comb begin
    if (state_q == null_src_sink_pkg::SRC_HEADER) begin
      // Sequence number and payload byte count
      o_src_beat.tdata = {seq_q, 13'd0, pkt_lines_q, 3'd0};
    end else begin
      o_src_beat.tdata = {seq_q, 16'd0, line_cnt_q};
    end
    o_src_beat.tlast = pkt_end;
  end

endmodule

`default_nettype wire

// ==== hdl/null_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

module null_sink (
  input  wire                                   i_ce_clk,
  input  wire                                   i_arst_n,
  input  wire                                   i_set_stb,
  input  wire null_src_sink_pkg::set_bus_t      i_set,
  input  wire null_src_sink_pkg::axis_beat_t    i_snk_beat,
  input  wire                                   i_snk_tvalid,
  output logic                                  o_snk_tready,
  output logic [null_src_sink_pkg::CNT_W-1:0]   o_pkt_count,
  output logic [null_src_sink_pkg::CNT_W-1:0]   o_line_count
);

  logic xfer;
  logic clear;

  // Data is dropped, so the input never stalls
  assign o_snk_tready = 1'b1;

  assign xfer  = i_snk_tvalid && o_snk_tready;
  assign clear = i_set_stb && (i_set.addr == null_src_sink_pkg::SR_CLEAR);

  //////////////////////////////
  // Traffic counters
  //////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_line_count <= '0;
    end else if (clear) begin
      o_line_count <= '0;
    end else if (xfer) begin
      o_line_count <= o_line_count + 32'd1;
    end
  end

  // Packets end on tlast
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pkt_count <= '0;
    end else if (clear) begin
      o_pkt_count <= '0;
    end else if (xfer && i_snk_beat.tlast) begin
      o_pkt_count <= o_pkt_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ctrl_readback.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_readback (
  input  wire                                        i_ce_clk,
  input  wire                                        i_arst_n,
  input  wire  [null_src_sink_pkg::SET_ADDR_W-1:0]   i_rb_addr,
  input  wire  [null_src_sink_pkg::CNT_W-1:0]        i_snk_pkts,
  input  wire  [null_src_sink_pkg::CNT_W-1:0]        i_snk_lines,
  input  wire  [null_src_sink_pkg::CNT_W-1:0]        i_src_pkts,
  input  wire  [null_src_sink_pkg::CNT_W-1:0]        i_settings,
  output logic [null_src_sink_pkg::RB_DATA_W-1:0]    o_rb_data
);

  null_src_sink_pkg::rb_sel_t                  sel;
  logic [null_src_sink_pkg::RB_DATA_W-1:0]     rb_mux;

  assign sel = null_src_sink_pkg::rb_sel_t'(i_rb_addr);

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb begin
    case (sel)
      null_src_sink_pkg::RB_NOC_ID:     rb_mux = null_src_sink_pkg::NOC_ID;
      null_src_sink_pkg::RB_SINK_PKTS:  rb_mux = {32'd0, i_snk_pkts};
      null_src_sink_pkg::RB_SINK_LINES: rb_mux = {32'd0, i_snk_lines};
      null_src_sink_pkg::RB_SRC_PKTS:   rb_mux = {32'd0, i_src_pkts};
      null_src_sink_pkg::RB_SETTINGS:   rb_mux = {32'd0, i_settings};
      // Unmapped addresses
      default:                          rb_mux = '0;
    endcase
  end

  // One cycle from address to data
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rb_data <= '0;
    end else begin
      o_rb_data <= rb_mux;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/null_src_sink_block.sv ====
`timescale 1ns/1ns
`default_nettype none

module null_src_sink_block (
  input  wire                                        i_ce_clk,
  input  wire                                        i_arst_n,
  // Settings bus
  input  wire                                        i_set_stb,
  input  wire null_src_sink_pkg::set_bus_t           i_set,
  // Output stream
  output null_src_sink_pkg::axis_beat_t              o_src_beat,
  output logic                                       o_src_tvalid,
  input  wire                                        i_src_tready,
  // Input stream
  input  wire null_src_sink_pkg::axis_beat_t         i_snk_beat,
  input  wire                                        i_snk_tvalid,
  output logic                                       o_snk_tready,
  // Readback
  input  wire  [null_src_sink_pkg::SET_ADDR_W-1:0]   i_rb_addr,
  output logic [null_src_sink_pkg::RB_DATA_W-1:0]    o_rb_data
);

  logic [null_src_sink_pkg::CNT_W-1:0] src_pkts;
  logic [null_src_sink_pkg::CNT_W-1:0] src_settings;
  logic [null_src_sink_pkg::CNT_W-1:0] snk_pkts;
  logic [null_src_sink_pkg::CNT_W-1:0] snk_lines;

  //////////////////////////////
  // Packet generator
  //////////////////////////////
  null_source u_source (
    .i_ce_clk     (i_ce_clk),
    .i_arst_n     (i_arst_n),
    .i_set_stb    (i_set_stb),
    .i_set        (i_set),
    .o_src_beat   (o_src_beat),
    .o_src_tvalid (o_src_tvalid),
    .i_src_tready (i_src_tready),
    .o_pkts_sent  (src_pkts),
    .o_settings   (src_settings)
  );

  //////////////////////////////
  // Discarding sink
  //////////////////////////////
  null_sink u_sink (
    .i_ce_clk     (i_ce_clk),
    .i_arst_n     (i_arst_n),
    .i_set_stb    (i_set_stb),
    .i_set        (i_set),
    .i_snk_beat   (i_snk_beat),
    .i_snk_tvalid (i_snk_tvalid),
    .o_snk_tready (o_snk_tready),
    .o_pkt_count  (snk_pkts),
    .o_line_count (snk_lines)
  );

  // Status words back to software
  ctrl_readback u_readback (
    .i_ce_clk    (i_ce_clk),
    .i_arst_n    (i_arst_n),
    .i_rb_addr   (i_rb_addr),
    .i_snk_pkts  (snk_pkts),
    .i_snk_lines (snk_lines),
    .i_src_pkts  (src_pkts),
    .i_settings  (src_settings),
    .o_rb_data   (o_rb_data)
  );

endmodule

`default_nettype wire

// ==== test/null_src_sink_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module null_src_sink_assert (
  input wire                                 i_ce_clk,
  input wire                                 i_arst_n,
  input wire null_src_sink_pkg::axis_beat_t  i_src_beat,
  input wire                                 i_src_tvalid,
  input wire                                 i_src_tready,
  input wire                                 i_snk_tready
);

  int fail_count = 0;

  // Stalled line must not move
  property src_hold_p;
    @(posedge i_ce_clk) disable iff (!i_arst_n)
      (i_src_tvalid && !i_src_tready) |=> (i_src_tvalid && $stable(i_src_beat));
  endproperty

  property snk_ready_p;
    @(posedge i_ce_clk) disable iff (!i_arst_n) i_snk_tready;
  endproperty

  property src_valid_known_p;
    @(posedge i_ce_clk) disable iff (!i_arst_n) !$isunknown(i_src_tvalid);
  endproperty

  src_hold_a : assert property (src_hold_p)
    else begin
      $error("source line or valid changed while stalled");
      fail_count++;
    end

  snk_ready_a : assert property (snk_ready_p)
    else begin
      $error("sink tready dropped after reset");
      fail_count++;
    end

  src_valid_known_a : assert property (src_valid_known_p)
    else begin
      $error("source tvalid is unknown");
      fail_count++;
    end

endmodule

bind null_src_sink_block null_src_sink_assert u_assert (
  .i_ce_clk     (i_ce_clk),
  .i_arst_n     (i_arst_n),
  .i_src_beat   (o_src_beat),
  .i_src_tvalid (o_src_tvalid),
  .i_src_tready (i_src_tready),
  .i_snk_tready (o_snk_tready)
);

`default_nettype wire

// ==== test/tb_null_src_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_null_src_sink;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  // Rough cycle budget of each test in running order
  localparam int TEST_CYCLES  = RESET_CYCLES + 40 + 60 + 200 + 60 + 200 + 150;
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                          ce_clk;
  logic                          arst_n;
  logic                          set_stb;
  null_src_sink_pkg::set_bus_t   set_word;
  null_src_sink_pkg::axis_beat_t src_beat;
  logic                          src_tvalid;
  logic                          src_tready;
  null_src_sink_pkg::axis_beat_t snk_beat;
  logic                          snk_tvalid;
  logic                          snk_tready;
  logic [7:0]                    rb_addr;
  logic [63:0]                   rb_data;

  logic [31:0] rng_state;
  // Reference model of the source stream
  logic [31:0] model_seq;
  int          model_idx;
  int          cur_lines;

  null_src_sink_block uut (
    .i_ce_clk     (ce_clk),
    .i_arst_n     (arst_n),
    .i_set_stb    (set_stb),
    .i_set        (set_word),
    .o_src_beat   (src_beat),
    .o_src_tvalid (src_tvalid),
    .i_src_tready (src_tready),
    .i_snk_beat   (snk_beat),
    .i_snk_tvalid (snk_tvalid),
    .o_snk_tready (snk_tready),
    .i_rb_addr    (rb_addr),
    .o_rb_data    (rb_data)
  );

  initial ce_clk = 1'b0;
  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic stop_on_failure();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp_val);
    assert (got === exp_val) else begin
      $display("Fail %s expected 0x%0h got 0x%0h", name, exp_val, got);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Header carries the byte count and payload its index
  function automatic null_src_sink_pkg::axis_beat_t expected_line(
      input logic [31:0] seq, input int idx, input int lines);
    null_src_sink_pkg::axis_beat_t b;
    if (idx < 0) begin
      b.tdata = {seq, 32'(lines * 8)};
      b.tlast = 1'b0;
    end else begin
      b.tdata = {seq, 32'(idx)};
      b.tlast = (idx == lines - 1);
    end
    return b;
  endfunction

  task automatic write_setting(input logic [7:0] waddr, input logic [31:0] wdata);
    @(posedge ce_clk);
    set_stb  <= 1'b1;
    set_word <= '{addr: waddr, data: wdata};
    @(posedge ce_clk);
    set_stb  <= 1'b0;
  endtask

  task automatic configure_source(input int lines, input int rate);
    write_setting(null_src_sink_pkg::SR_LINES, 32'(lines));
    write_setting(null_src_sink_pkg::SR_RATE, 32'(rate));
    cur_lines = (lines == 0) ? 1 : lines;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [63:0] exp_val,
                            input string name);
    @(posedge ce_clk);
    rb_addr <= addr;
    @(posedge ce_clk);
    @(negedge ce_clk);
    check_value(name, rb_data, exp_val);
  endtask

  // Enables the source, checks every accepted line, disables after dis_line lines
  task automatic run_source(input int n_pkts, input int dis_line, input bit rand_ready,
                            input int exp_gap);
    int lines_seen;
    int pkts_seen;
    int idle;
    bit send_dis;
    bit first;
    logic [31:0] r;
    null_src_sink_pkg::axis_beat_t exp_beat;
    lines_seen = 0;
    pkts_seen  = 0;
    idle       = 0;
    first      = 1'b1;
    send_dis   = (dis_line == 0);
    write_setting(null_src_sink_pkg::SR_ENABLE, 32'd1);
    while (pkts_seen < n_pkts) begin
      @(posedge ce_clk);
      r = next_random();
      src_tready <= rand_ready ? (r[1:0] != 2'd0) : 1'b1;
      if (send_dis) begin
        set_stb  <= 1'b1;
        set_word <= '{addr: null_src_sink_pkg::SR_ENABLE, data: 32'd0};
        send_dis = 1'b0;
      end else begin
        set_stb <= 1'b0;
      end
      @(negedge ce_clk);
      if (src_tvalid && src_tready) begin
        if (exp_gap >= 0 && !first) begin
          check_value("idle cycles before o_src_tvalid", idle, exp_gap);
        end
        exp_beat = expected_line(model_seq, model_idx, cur_lines);
        check_value("o_src_beat.tdata", src_beat.tdata, exp_beat.tdata);
        check_value("o_src_beat.tlast", src_beat.tlast, exp_beat.tlast);
        if (model_idx == cur_lines - 1) begin
          model_idx = -1;
          model_seq = model_seq + 32'd1;
          pkts_seen++;
        end else begin
          model_idx++;
        end
        lines_seen++;
        idle  = 0;
        first = 1'b0;
        if (lines_seen == dis_line) begin
          send_dis = 1'b1;
        end
      end else if (!src_tvalid) begin
        idle++;
      end
    end
    @(posedge ce_clk);
    set_stb <= 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic reset_state();
    repeat (5) begin
      @(negedge ce_clk);
      check_value("o_src_tvalid", src_tvalid, 1'b0);
      check_value("o_snk_tready", snk_tready, 1'b1);
    end
    read_check(null_src_sink_pkg::RB_NOC_ID, null_src_sink_pkg::NOC_ID, "o_rb_data noc id");
    read_check(null_src_sink_pkg::RB_SINK_PKTS, 64'd0, "o_rb_data sink pkts");
    read_check(null_src_sink_pkg::RB_SINK_LINES, 64'd0, "o_rb_data sink lines");
    read_check(null_src_sink_pkg::RB_SRC_PKTS, 64'd0, "o_rb_data src pkts");
    read_check(null_src_sink_pkg::RB_SETTINGS, 64'h1, "o_rb_data settings");
    read_check(8'd5, 64'd0, "o_rb_data unmapped 0x05");
    read_check(8'hff, 64'd0, "o_rb_data unmapped 0xff");
  endtask

  task automatic packet_format();
    configure_source(4, 0);
    run_source(3, 11, 1'b0, 0);
    read_check(null_src_sink_pkg::RB_SRC_PKTS, 64'd3, "o_rb_data src pkts");
  endtask

  task automatic back_pressure();
    configure_source(5, 0);
    run_source(3, 13, 1'b1, -1);
    read_check(null_src_sink_pkg::RB_SRC_PKTS, 64'd6, "o_rb_data src pkts");
  endtask

  task automatic pacing();
    configure_source(2, 3);
    run_source(2, 4, 1'b0, 3);
    read_check(null_src_sink_pkg::RB_SRC_PKTS, 64'd8, "o_rb_data src pkts");
  endtask

  task automatic sink_counting();
    int n_pkts;
    int len;
    int pkts;
    int lines;
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    pkts   = 0;
    lines  = 0;
    r      = next_random();
    n_pkts = 3 + int'(r % 4);
    // Trailing pass adds two lines with no tlast
    for (int p = 0; p <= n_pkts; p++) begin
      r   = next_random();
      len = (p == n_pkts) ? 2 : 1 + int'(r % 6);
      for (int k = 0; k < len; k++) begin
        r = next_random();
        if (r[2:0] == 3'd0) begin
          @(posedge ce_clk);
          snk_tvalid <= 1'b0;
        end
        hi = next_random();
        lo = next_random();
        @(posedge ce_clk);
        snk_tvalid <= 1'b1;
        snk_beat   <= '{tdata: {hi, lo}, tlast: (p < n_pkts) && (k == len - 1)};
        lines++;
        if ((p < n_pkts) && (k == len - 1)) begin
          pkts++;
        end
      end
    end
    @(posedge ce_clk);
    snk_tvalid <= 1'b0;
    read_check(null_src_sink_pkg::RB_SINK_PKTS, 64'(pkts), "o_rb_data sink pkts");
    read_check(null_src_sink_pkg::RB_SINK_LINES, 64'(lines), "o_rb_data sink lines");
    write_setting(null_src_sink_pkg::SR_CLEAR, 32'd0);
    read_check(null_src_sink_pkg::RB_SINK_PKTS, 64'd0, "o_rb_data sink pkts");
    read_check(null_src_sink_pkg::RB_SINK_LINES, 64'd0, "o_rb_data sink lines");
    configure_source(7, 5);
    read_check(null_src_sink_pkg::RB_SETTINGS, 64'h0005_0007, "o_rb_data settings");
  endtask

  task automatic disable_stop();
    configure_source(6, 1);
    // Enable drops after the header and two payload lines
    run_source(1, 3, 1'b1, -1);
    @(posedge ce_clk);
    src_tready <= 1'b1;
    repeat (50) begin
      @(negedge ce_clk);
      check_value("o_src_tvalid", src_tvalid, 1'b0);
    end
    read_check(null_src_sink_pkg::RB_SRC_PKTS, 64'd9, "o_rb_data src pkts");
  endtask

  //////////////////////////////
  // Sequencing
  //////////////////////////////
  initial begin
    arst_n     = 1'b0;
    set_stb    = 1'b0;
    set_word   = '0;
    src_tready = 1'b0;
    snk_beat   = '0;
    snk_tvalid = 1'b0;
    rb_addr    = '0;
    rng_state  = 32'h2089_280f;
    model_seq  = '0;
    model_idx  = -1;
    cur_lines  = 1;
    repeat (RESET_CYCLES) @(posedge ce_clk);
    check_value("o_rb_data", rb_data, 64'd0);
    arst_n <= 1'b1;
    reset_state();
    packet_format();
    back_pressure();
    pacing();
    sink_counting();
    disable_stop();
    repeat (2) @(posedge ce_clk);
    if (uut.u_assert.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("A stream protocol assertion failed");
      stop_on_failure();
    end
  end

  always @(posedge ce_clk) begin
    if (uut.u_assert.fail_count != 0) begin
      $display("A stream protocol assertion failed");
      stop_on_failure();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    stop_on_failure();
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/null_src_sink_pkg.sv
hdl/null_source.sv
hdl/null_sink.sv
hdl/ctrl_readback.sv
hdl/null_src_sink_block.sv
test/null_src_sink_assert.sv
test/tb_null_src_sink.sv

// ==== Bender.yml ====
package:
  name: null_src_sink

dependencies: {}

sources:
  # Synthesizable block
  - files:
      - hdl/null_src_sink_pkg.sv
      - hdl/null_source.sv
      - hdl/null_sink.sv
      - hdl/ctrl_readback.sv
      - hdl/null_src_sink_block.sv

  # Simulation only
  - target: test
    files:
      - test/null_src_sink_assert.sv
      - test/tb_null_src_sink.sv
